/* hw/psgPkg.sv */
`default_nettype none

package psgPkg;

	// ==============================
	// sizes
	// ==============================

	// wave-table channels sharing the memory bus
	localparam int NumChan = 8;
	localparam int ChanIdxW = 3;

	// memory word address and data
	localparam int AddrW = 16;
	localparam int DataW = 16;

	// table length and offset within a table
	localparam int LenW = 8;

	// ==============================
	// types
	// ==============================

	typedef logic [ChanIdxW-1:0] chanIdx_t;

	// one bit per channel for requests, grants and done strobes
	typedef logic [NumChan-1:0] chanMask_t;

	typedef logic [AddrW-1:0] addr_t;
	typedef logic [DataW-1:0] sample_t;

	// per channel settings
	// a length of 0 stands for a full 256 word table
	typedef struct packed {
		logic            enable;
		addr_t           base;
		logic [LenW-1:0] len;
	} chanCfg_t;

endpackage

`default_nettype wire

/* hw/psgBusArb.sv */
`timescale 1ns/1ps
`default_nettype none

module psgBusArb (
	input  logic              clk,
	input  logic              rst,
	input  logic              ce,
	input  logic              ack,
	input  psgPkg::chanMask_t req,
	output psgPkg::chanMask_t sel,
	output psgPkg::chanIdx_t  seln
);
	import psgPkg::*;

	chanMask_t winMask;
	chanIdx_t  winIdx;
	logic      anyReq;
	logic      update;

	// ==============================
	// priority scan
	// ==============================

	// walk from the top down so the lowest requester is written last and wins
	always_comb begin
		winMask = '0;
		winIdx = '0;
		for (int i = NumChan - 1; i >= 0; i--) begin
			if (req[i]) begin
				winMask = chanMask_t'(1) << i;
				winIdx = chanIdx_t'(i);
			end
		end
	end

	assign anyReq = |req;

	// grant moves only while the bus is free and the PSG clock is enabled
	// an empty request vector leaves the last owner in place
	assign update = ce & ack & anyReq;

	// ==============================
	// grant register
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			seln <= '0;
		end else if (update) begin
			sel <= winMask;
			seln <= winIdx;
		end
	end

endmodule

`default_nettype wire

/* hw/psgWaveFetch.sv */
`timescale 1ns/1ps
`default_nettype none

module psgWaveFetch (
	input  logic             clk,
	input  logic             rst,
	input  logic             cfgWr,
	input  psgPkg::chanCfg_t cfgIn,
	input  logic             sampleTick,
	input  logic             done,
	input  psgPkg::sample_t  rdData,
	output logic             req,
	output psgPkg::addr_t    addr,
	output psgPkg::sample_t  sample
);
	import psgPkg::*;

	chanCfg_t        cfgReg;
	logic [LenW-1:0] offset;
	logic [LenW-1:0] offsetInc;
	logic [LenW-1:0] offsetNext;

	// ==============================
	// channel settings
	// ==============================

	// latched on a write addressed to this channel
	always_ff @(posedge clk) begin
		if (rst) begin
			cfgReg.enable <= 1'b0;
		end else if (cfgWr) begin
			cfgReg <= cfgIn;
		end
	end

	// ==============================
	// table offset
	// ==============================

	assign offsetInc = offset + 1'b1;

	// wrap back to the table start at the programmed length
	// a length of 0 wraps by the natural 8 bit overflow
	assign offsetNext = (offsetInc == cfgReg.len) ? '0 : offsetInc;

	always_ff @(posedge clk) begin
		if (rst) begin
			offset <= '0;
		end else if (cfgWr) begin
			// new settings restart the table
			offset <= '0;
		end else if (done) begin
			offset <= offsetNext;
		end
	end

	// word address of the next sample
	assign addr = cfgReg.base + addr_t'(offset);

	// ==============================
	// request level
	// ==============================

	// raised by a tick, dropped when the read for this channel completes
	// a tick arriving while a request is pending has no further effect
	always_ff @(posedge clk) begin
		if (rst) begin
			req <= 1'b0;
		end else if (!cfgReg.enable) begin
			req <= 1'b0;
		end else if (done) begin
			req <= 1'b0;
		end else if (sampleTick) begin
			req <= 1'b1;
		end
	end

	// ==============================
	// current sample
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			sample <= '0;
		end else if (done) begin
			sample <= rdData;
		end
	end

endmodule

`default_nettype wire

/* hw/psgBusMaster.sv */
`timescale 1ns/1ps
`default_nettype none

module psgBusMaster (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 ce,
	input  psgPkg::chanMask_t                    sel,
	input  psgPkg::chanIdx_t                     seln,
	input  psgPkg::chanMask_t                    req,
	input  psgPkg::addr_t [psgPkg::NumChan-1:0]  chanAddr,
	input  logic                                 memAck,
	input  psgPkg::sample_t                      memData,
	output logic                                 busFree,
	output logic                                 memCyc,
	output psgPkg::addr_t                        memAddr,
	output psgPkg::chanMask_t                    doneMask,
	output psgPkg::sample_t                      rdData
);
	import psgPkg::*;

	typedef enum logic [1:0] {
		Idle,
		Busy,
		Done
	} state_t;

	state_t   state;
	state_t   stateNext;
	chanIdx_t curChan;
	logic     start;
	logic     finish;

	// the granted owner must still be asking for the bus
	// a channel that was just served has already dropped its request
	assign start = (state == Idle) && ce && (|(sel & req));

	// memory may hold off ack for any number of cycles
	assign finish = (state == Busy) && memAck;

	// arbiter may only move while nothing is in flight
	assign busFree = (state == Idle);

	// ==============================
	// state machine
	// ==============================

	always_comb begin
		stateNext = state;
		case (state)
			Idle: begin
				if (start) begin
					stateNext = Busy;
				end
			end
			Busy: begin
				if (memAck) begin
					stateNext = Done;
				end
			end
			Done: begin
				// one cycle for the done strobe, then free the bus
				stateNext = Idle;
			end
			default: begin
				stateNext = Idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= Idle;
		end else begin
			state <= stateNext;
		end
	end

	// ==============================
	// bus cycle and done strobe
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			memCyc <= 1'b0;
		end else if (start) begin
			memCyc <= 1'b1;
		end else if (finish) begin
			memCyc <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			doneMask <= '0;
		end else if (finish) begin
			doneMask <= chanMask_t'(1) << curChan;
		end else begin
			doneMask <= '0;
		end
	end

	// ==============================
	// datapath
	// ==============================

	// channel and address are captured once so they stay stable under back-pressure
	always_ff @(posedge clk) begin
		if (start) begin
			curChan <= seln;
			memAddr <= chanAddr[seln];
		end
	end

	// shared return word, qualified by doneMask at the channels
	always_ff @(posedge clk) begin
		if (finish) begin
			rdData <= memData;
		end
	end

endmodule

`default_nettype wire

/* hw/psgWaveSys.sv */
`timescale 1ns/1ps
`default_nettype none

module psgWaveSys (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   ce,
	input  logic                                   sampleTick,
	input  logic                                   cfgWr,
	input  psgPkg::chanIdx_t                       cfgChan,
	input  psgPkg::chanCfg_t                       cfg,
	input  logic                                   memAck,
	input  psgPkg::sample_t                        memData,
	output logic                                   memCyc,
	output psgPkg::addr_t                          memAddr,
	output psgPkg::sample_t [psgPkg::NumChan-1:0]  samples
);
	import psgPkg::*;

	chanMask_t             reqMask;
	chanMask_t             sel;
	chanMask_t             doneMask;
	chanIdx_t              seln;
	addr_t [NumChan-1:0]   chanAddr;
	sample_t               rdData;
	logic                  busFree;

	// ==============================
	// wave-table channels
	// ==============================

	// each channel picks off its own bit of the shared vectors
	// the config strobe is steered by the channel number
	for (genvar i = 0; i < NumChan; i++) begin : g_chan
		psgWaveFetch i_fetch (
			.clk        (clk),
			.rst        (rst),
			.cfgWr      (cfgWr && (cfgChan == chanIdx_t'(i))),
			.cfgIn      (cfg),
			.sampleTick (sampleTick),
			.done       (doneMask[i]),
			.rdData     (rdData),
			.req        (reqMask[i]),
			.addr       (chanAddr[i]),
			.sample     (samples[i])
		);
	end

	// ==============================
	// bus ownership
	// ==============================

	// re-evaluated only while the master is idle, so an owner keeps
	// the bus for its whole transfer
	psgBusArb i_arb (
		.clk  (clk),
		.rst  (rst),
		.ce   (ce),
		.ack  (busFree),
		.req  (reqMask),
		.sel  (sel),
		.seln (seln)
	);

	// ==============================
	// memory read
	// ==============================

	psgBusMaster i_master (
		.clk      (clk),
		.rst      (rst),
		.ce       (ce),
		.sel      (sel),
		.seln     (seln),
		.req      (reqMask),
		.chanAddr (chanAddr),
		.memAck   (memAck),
		.memData  (memData),
		.busFree  (busFree),
		.memCyc   (memCyc),
		.memAddr  (memAddr),
		.doneMask (doneMask),
		.rdData   (rdData)
	);

endmodule

`default_nettype wire

/* test/psgBusArb_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module psgBusArbChk (
	input logic              clk,
	input logic              rst,
	input logic              ce,
	input logic              ack,
	input psgPkg::chanMask_t sel,
	input psgPkg::chanIdx_t  seln
);
	import psgPkg::*;

	// never more than one owner
	selOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(sel))
		else $error("arbiter grant has more than one bit set");

	// the index must name the granted channel
	selIndex: assert property (@(posedge clk) disable iff (rst)
		(sel != '0) |-> (sel == (chanMask_t'(1) << seln)))
		else $error("arbiter grant index does not match the grant mask");

	// grant moves only with ce and a free bus
	selHold: assert property (@(posedge clk) disable iff (rst)
		!(ce && ack) |=> ($stable(sel) && $stable(seln)))
		else $error("arbiter grant changed while the bus was busy or ce was low");

endmodule

bind psgBusArb psgBusArbChk i_chk (
	.clk  (clk),
	.rst  (rst),
	.ce   (ce),
	.ack  (ack),
	.sel  (sel),
	.seln (seln)
);

`default_nettype wire

/* test/psgWaveSysTb.sv */
`timescale 1ns/1ps
`default_nettype none

module psgWaveSysTb;
	import psgPkg::*;

	localparam int ClkHalf = 4;
	localparam int ResetCycles = 10;
	// 31 reads at up to 10 cycles each and under 20 with stretched acks
	// plus config writes and the ce stall
	localparam int TimeoutCycles = 4000;
	localparam sample_t DataMask = 16'hA5C3;
	localparam int NormalDelay = 5;
	localparam int LongDelay = 12;
	localparam int StallCycles = 30;

	logic                  clk;
	logic                  rst;
	logic                  ce;
	logic                  sampleTick;
	logic                  cfgWr;
	chanIdx_t              cfgChan;
	chanCfg_t              cfg;
	logic                  memAck;
	sample_t               memData;
	logic                  memCyc;
	addr_t                 memAddr;
	sample_t [NumChan-1:0] samples;

	// reference state of every channel
	addr_t           expBase [NumChan];
	logic [LenW-1:0] expLen [NumChan];
	logic [LenW-1:0] expOffset [NumChan];
	int              lastOwner;
	int              maxDelay;
	int              errors;
	int              checks;
	int unsigned     seed;

	psgWaveSys i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #ClkHalf clk = ~clk;
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles >= TimeoutCycles) begin
				$display("Timeout after %0d cycles, a fetch never completed", cycles);
				$display("Some tests failed");
				$finish;
			end
		end
	end

	// ==============================
	// memory model
	// ==============================

	// data word is the address scrambled with a fixed mask
	initial begin : memModel
		int waitCnt;
		int ackDelay;
		waitCnt = 0;
		ackDelay = 0;
		memAck <= 1'b0;
		memData <= '0;
		forever begin
			@(posedge clk);
			if (rst || memAck) begin
				memAck <= 1'b0;
				waitCnt = 0;
			end else if (memCyc) begin
				if (waitCnt >= ackDelay) begin
					memAck <= 1'b1;
					memData <= memAddr ^ DataMask;
					waitCnt = 0;
					ackDelay = int'($urandom % (maxDelay + 1));
				end else begin
					waitCnt++;
				end
			end
		end
	end

	// ==============================
	// helpers
	// ==============================

	task automatic checkValue(input string name, input logic [15:0] actual,
			input logic [15:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, actual, expected);
		end
	endtask

	function automatic addr_t expectedAddr(input int ch);
		return expBase[ch] + addr_t'(expOffset[ch]);
	endfunction

	// length 0 means a full 256 word table
	function automatic void advanceOffset(input int ch);
		logic [LenW-1:0] next;
		next = expOffset[ch] + 8'd1;
		if (next == expLen[ch]) begin
			next = '0;
		end
		expOffset[ch] = next;
	endfunction

	task automatic writeConfig(input int ch, input logic en, input addr_t base,
			input logic [LenW-1:0] len);
		@(posedge clk);
		cfgWr <= 1'b1;
		cfgChan <= chanIdx_t'(ch);
		cfg.enable <= en;
		cfg.base <= base;
		cfg.len <= len;
		@(posedge clk);
		cfgWr <= 1'b0;
		expBase[ch] = base;
		expLen[ch] = len;
		expOffset[ch] = '0;
	endtask

	task automatic pulseTick();
		@(posedge clk);
		sampleTick <= 1'b1;
		@(posedge clk);
		sampleTick <= 1'b0;
	endtask

	// one tick for the channels in mask with an optional ce stall
	task automatic runFetch(input chanMask_t mask, input int stall);
		sample_t prev [NumChan];
		addr_t   starts [$];
		int      order [$];
		addr_t   heldAddr;
		logic    prevCyc;
		logic    allDone;
		for (int i = 0; i < NumChan; i++) begin
			prev[i] = samples[i];
		end
		// the held owner goes first while it still asks and the rest follow by priority
		if (lastOwner >= 0) begin
			if (mask[lastOwner]) begin
				order.push_back(lastOwner);
			end
		end
		for (int i = 0; i < NumChan; i++) begin
			if (mask[i] && i != lastOwner) begin
				order.push_back(i);
			end
		end
		if (stall > 0) begin
			@(posedge clk);
			ce <= 1'b0;
		end
		pulseTick();
		repeat (stall) begin
			@(negedge clk);
			checkValue("memCyc", 16'(memCyc), 16'h0000);
		end
		if (stall > 0) begin
			@(posedge clk);
			ce <= 1'b1;
		end
		// follow the bus until every requested channel shows a new sample
		heldAddr = '0;
		prevCyc = 1'b0;
		allDone = 1'b0;
		while (!allDone) begin
			@(negedge clk);
			if (memCyc && !prevCyc) begin
				starts.push_back(memAddr);
				heldAddr = memAddr;
			end else if (memCyc) begin
				checkValue("memAddr", memAddr, heldAddr);
			end
			prevCyc = memCyc;
			allDone = 1'b1;
			for (int i = 0; i < NumChan; i++) begin
				if (mask[i] && samples[i] == prev[i]) begin
					allDone = 1'b0;
				end
			end
		end
		checkValue("memCyc starts", 16'(starts.size()), 16'(order.size()));
		for (int k = 0; k < order.size() && k < starts.size(); k++) begin
			checkValue($sformatf("memAddr of read %0d", k), starts[k], expectedAddr(order[k]));
		end
		for (int i = 0; i < NumChan; i++) begin
			if (mask[i]) begin
				checkValue($sformatf("samples[%0d]", i), samples[i], expectedAddr(i) ^ DataMask);
				advanceOffset(i);
			end else begin
				checkValue($sformatf("samples[%0d]", i), samples[i], prev[i]);
			end
		end
		lastOwner = order[order.size() - 1];
	endtask

	// ==============================
	// tests
	// ==============================

	task automatic testReset();
		@(negedge clk);
		checkValue("memCyc", 16'(memCyc), 16'h0000);
		for (int i = 0; i < NumChan; i++) begin
			checkValue($sformatf("samples[%0d]", i), samples[i], 16'h0000);
		end
	endtask

	task automatic testSingle();
		writeConfig(3, 1'b1, 16'h0100, 8'd4);
		runFetch(8'h08, 0);
	endtask

	// offsets run 1, 2, 3, then wrap to 0
	task automatic testWrap();
		repeat (6) begin
			runFetch(8'h08, 0);
		end
	endtask

	task automatic testPriority();
		for (int i = 0; i < NumChan; i++) begin
			writeConfig(i, 1'b1, addr_t'(16'h1000 + i * 16'h0200), 8'd16);
		end
		runFetch(8'hFF, 0);
	endtask

	task automatic testBackPressure();
		maxDelay = LongDelay;
		runFetch(8'hFF, 0);
		maxDelay = NormalDelay;
	endtask

	task automatic testClockEnable();
		runFetch(8'hFF, StallCycles);
	endtask

	initial begin
		seed = $urandom(61845);
		maxDelay = NormalDelay;
		lastOwner = -1;
		errors = 0;
		checks = 0;
		for (int i = 0; i < NumChan; i++) begin
			expBase[i] = '0;
			expLen[i] = '0;
			expOffset[i] = '0;
		end
		rst <= 1'b1;
		ce <= 1'b1;
		sampleTick <= 1'b0;
		cfgWr <= 1'b0;
		cfgChan <= '0;
		cfg <= '0;
		repeat (ResetCycles) @(posedge clk);
		rst <= 1'b0;
		testReset();
		testSingle();
		testWrap();
		testPriority();
		testBackPressure();
		testClockEnable();
		$display("%0d checks done, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
hw/psgPkg.sv
hw/psgBusArb.sv
hw/psgWaveFetch.sv
hw/psgBusMaster.sv
hw/psgWaveSys.sv
test/psgBusArb_chk.sv
test/psgWaveSysTb.sv

/* sim.sh */
#!/bin/sh
# build the wave-table fetch testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module psgWaveSysTb \
	-f verilog.f -o psgWaveSysTb; then
	echo "build failed"
	exit 1
fi

out=$(./obj_dir/psgWaveSysTb)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
	exit 0
fi
exit 1
